//--- Makefile
VERILATOR   ?= verilator
TOP         := cube_engine_tb
FILELIST    := compile.f
OBJ_DIR     := obj_dir
BUILD_FLAGS := --binary --assert -j 0
LINT_FLAGS  := --lint-only --timing --assert
PASS_MSG    := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
+incdir+verification
logic/cube_pkg.sv
logic/stream_fifo.sv
logic/cube_turn.sv
logic/cube_monitor.sv
logic/cube_engine.sv
verification/cube_engine_tb.sv

//--- logic/cube_engine.sv
`timescale 1ns/1ps
`default_nettype none

module cube_engine #(
  parameter int CMD_DEPTH = 4,
  parameter int RPT_DEPTH = 2
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  cube_pkg::cube_cmd_t    cmd,
  output logic                   rpt_valid,
  input  logic                   rpt_ready,
  output cube_pkg::cube_report_t rpt
);

  import cube_pkg::*;

  logic         q_cmd_valid;
  logic         q_cmd_ready;
  cube_cmd_t    q_cmd;
  logic         step_valid;
  logic         step_ready;
  cube_step_t   step;
  logic         mon_rpt_valid;
  logic         mon_rpt_ready;
  cube_report_t mon_rpt;

  stream_fifo #(
    .item_t (cube_cmd_t),
    .DEPTH  (CMD_DEPTH)
  ) u_cmd_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .in_item   (cmd),
    .out_valid (q_cmd_valid),
    .out_ready (q_cmd_ready),
    .out_item  (q_cmd)
  );

  cube_turn u_turn (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (q_cmd_valid),
    .cmd_ready  (q_cmd_ready),
    .cmd        (q_cmd),
    .step_valid (step_valid),
    .step_ready (step_ready),
    .step       (step)
  );

  cube_monitor u_monitor (
    .clk        (clk),
    .rst_n      (rst_n),
    .step_valid (step_valid),
    .step_ready (step_ready),
    .step       (step),
    .rpt_valid  (mon_rpt_valid),
    .rpt_ready  (mon_rpt_ready),
    .rpt        (mon_rpt)
  );

  stream_fifo #(
    .item_t (cube_report_t),
    .DEPTH  (RPT_DEPTH)
  ) u_rpt_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (mon_rpt_valid),
    .in_ready  (mon_rpt_ready),
    .in_item   (mon_rpt),
    .out_valid (rpt_valid),
    .out_ready (rpt_ready),
    .out_item  (rpt)
  );

endmodule

`default_nettype wire

//--- logic/cube_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module cube_monitor (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   step_valid,
  output logic                   step_ready,
  input  cube_pkg::cube_step_t   step,
  output logic                   rpt_valid,
  input  logic                   rpt_ready,
  output cube_pkg::cube_report_t rpt
);

  import cube_pkg::*;

  logic [15:0] count_q;
  logic        is_report;
  logic        take;
  logic        solved;

  assign is_report  = (step.kind == cmd_report);
  assign step_ready = !is_report || rpt_ready;  // Only reports can stall
  assign take       = step_valid && step_ready;
  assign rpt_valid  = step_valid && is_report;

  always_comb begin
    cube_state_t masked;
    masked = step.state;
    for (int i = 4; i < 8; i++) begin
      masked.corner_perm[i]  = '0;
      masked.corner_twist[i] = '0;
    end
    solved = (masked == solved_state);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (take) begin
      if (step.kind == cmd_load) begin
        count_q <= '0;
      end else if (step.counted && (count_q != '1)) begin
        count_q <= count_q + 1'b1;  // Saturates
      end
    end
  end

  assign rpt = '{state: step.state, solved: solved, turns: count_q};

endmodule

`default_nettype wire

//--- logic/cube_pkg.sv
`default_nettype none

package cube_pkg;

  // Corner perm in the low bits and edge flips on top
  typedef struct packed {
    logic [11:0]      edge_flip;
    logic [11:0][3:0] edge_perm;
    logic [11:0][1:0] corner_twist;
    logic [11:0][2:0] corner_perm;  // Slots 4-7 unused
  } cube_state_t;

  typedef enum logic [3:0] {
    mv_stay    = 4'd0,
    mv_u       = 4'd1,
    mv_u_prime = 4'd2,
    mv_d       = 4'd3,
    mv_d_prime = 4'd4,
    mv_f       = 4'd5,
    mv_f_prime = 4'd6,
    mv_b       = 4'd7,
    mv_b_prime = 4'd8,
    mv_r       = 4'd9,
    mv_r_prime = 4'd10,
    mv_l       = 4'd11,
    mv_l_prime = 4'd12
  } move_t;

  typedef enum logic [1:0] {
    cmd_load   = 2'd0,
    cmd_turn   = 2'd1,
    cmd_report = 2'd2
  } cmd_kind_t;

  typedef struct packed {
    cmd_kind_t   kind;
    move_t       move;
    cube_state_t state;  // Load only
  } cube_cmd_t;

  typedef struct packed {
    cmd_kind_t   kind;
    logic        counted;
    cube_state_t state;
  } cube_step_t;

  typedef struct packed {
    cube_state_t state;
    logic        solved;
    logic [15:0] turns;
  } cube_report_t;

  localparam cube_state_t solved_state = '{
    edge_flip:    '0,
    edge_perm:    {4'd11, 4'd10, 4'd9, 4'd8, 4'd7, 4'd6,
                   4'd5, 4'd4, 4'd3, 4'd2, 4'd1, 4'd0},
    corner_twist: '0,
    corner_perm:  {3'd7, 3'd6, 3'd5, 3'd4, 3'd0, 3'd0,
                   3'd0, 3'd0, 3'd3, 3'd2, 3'd1, 3'd0}
  };

endpackage

`default_nettype wire

//--- logic/cube_turn.sv
`timescale 1ns/1ps
`default_nettype none

module cube_turn (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmd_valid,
  output logic                 cmd_ready,
  input  cube_pkg::cube_cmd_t  cmd,
  output logic                 step_valid,
  input  logic                 step_ready,
  output cube_pkg::cube_step_t step
);

  import cube_pkg::*;

  cube_state_t state_q;
  cube_state_t state_d;
  cmd_kind_t   kind_q;
  logic        counted_q;
  logic        take;

  // 0 -> 1 -> 2 -> 0
  function automatic logic [1:0] twist_cw(input logic [1:0] t);
    return {t[0], ~|t};
  endfunction

  // 0 -> 2 -> 1 -> 0
  function automatic logic [1:0] twist_ccw(input logic [1:0] t);
    return {~|t, t[1]};
  endfunction

  // Piece in slot c[k] moves to slot c[k+1] around a 4-cycle
  function automatic cube_state_t apply_turn(input cube_state_t s, input move_t m);
    cube_state_t     n;
    logic [0:3][3:0] cc;
    logic [0:3][3:0] ec;
    logic            twist;
    logic            flip;
    logic [3:0]      src;
    logic [3:0]      dst;
    n     = s;
    cc    = '0;
    ec    = '0;
    twist = 1'b0;
    flip  = 1'b0;
    case (m)
      mv_u: begin
        cc = {4'd0, 4'd1, 4'd2, 4'd3};
        ec = {4'd0, 4'd1, 4'd2, 4'd3};
      end
      mv_u_prime: begin
        cc = {4'd0, 4'd3, 4'd2, 4'd1};
        ec = {4'd0, 4'd3, 4'd2, 4'd1};
      end
      mv_d: begin
        cc = {4'd8, 4'd11, 4'd10, 4'd9};
        ec = {4'd8, 4'd11, 4'd10, 4'd9};
      end
      mv_d_prime: begin
        cc = {4'd8, 4'd9, 4'd10, 4'd11};
        ec = {4'd8, 4'd9, 4'd10, 4'd11};
      end
      mv_f: begin
        cc    = {4'd2, 4'd10, 4'd11, 4'd3};
        ec    = {4'd2, 4'd6, 4'd10, 4'd7};
        twist = 1'b1;
        flip  = 1'b1;
      end
      mv_f_prime: begin
        cc    = {4'd2, 4'd3, 4'd11, 4'd10};
        ec    = {4'd2, 4'd7, 4'd10, 4'd6};
        twist = 1'b1;
        flip  = 1'b1;
      end
      mv_b: begin
        cc    = {4'd0, 4'd8, 4'd9, 4'd1};
        ec    = {4'd0, 4'd4, 4'd8, 4'd5};
        twist = 1'b1;
        flip  = 1'b1;
      end
      mv_b_prime: begin
        cc    = {4'd0, 4'd1, 4'd9, 4'd8};
        ec    = {4'd0, 4'd5, 4'd8, 4'd4};
        twist = 1'b1;
        flip  = 1'b1;
      end
      mv_r: begin
        cc    = {4'd1, 4'd9, 4'd10, 4'd2};
        ec    = {4'd1, 4'd5, 4'd9, 4'd6};
        twist = 1'b1;
      end
      mv_r_prime: begin
        cc    = {4'd1, 4'd2, 4'd10, 4'd9};
        ec    = {4'd1, 4'd6, 4'd9, 4'd5};
        twist = 1'b1;
      end
      mv_l: begin
        cc    = {4'd3, 4'd11, 4'd8, 4'd0};
        ec    = {4'd3, 4'd7, 4'd11, 4'd4};
        twist = 1'b1;
      end
      mv_l_prime: begin
        cc    = {4'd3, 4'd0, 4'd8, 4'd11};
        ec    = {4'd3, 4'd4, 4'd11, 4'd7};
        twist = 1'b1;
      end
      default: return s;  // Stay and spare codes
    endcase
    for (int k = 0; k < 4; k++) begin
      src = cc[k];
      dst = cc[(k + 1) % 4];
      n.corner_perm[dst] = s.corner_perm[src];
      if (!twist) begin
        n.corner_twist[dst] = s.corner_twist[src];
      end else if (k % 2 == 0) begin
        n.corner_twist[dst] = twist_cw(s.corner_twist[src]);
      end else begin
        n.corner_twist[dst] = twist_ccw(s.corner_twist[src]);
      end
      src = ec[k];
      dst = ec[(k + 1) % 4];
      n.edge_perm[dst] = s.edge_perm[src];
      n.edge_flip[dst] = s.edge_flip[src] ^ flip;
    end
    return n;
  endfunction

  assign cmd_ready = !step_valid || step_ready;
  assign take      = cmd_valid && cmd_ready;

  always_comb begin
    case (cmd.kind)
      cmd_load: state_d = cmd.state;
      cmd_turn: state_d = apply_turn(state_q, cmd.move);
      default:  state_d = state_q;  // Report leaves state alone
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= '0;
      step_valid <= 1'b0;
    end else begin
      if (take) begin
        state_q <= state_d;
      end
      if (cmd_ready) begin
        step_valid <= cmd_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      kind_q    <= cmd.kind;
      counted_q <= (cmd.kind == cmd_turn) && (cmd.move != mv_stay) &&
                   (cmd.move <= mv_l_prime);
    end
  end

  assign step = '{kind: kind_q, counted: counted_q, state: state_q};

endmodule

`default_nettype wire

//--- logic/stream_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type item_t = logic [7:0],
  parameter int DEPTH = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  output logic  in_ready,
  input  item_t in_item,
  output logic  out_valid,
  input  logic  out_ready,
  output item_t out_item
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign out_valid = (count != '0);
  assign in_ready  = (count != FULL_COUNT) || out_ready;  // Full but draining
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_item  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_item;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verification/cube_checks.svh
`ifndef CUBE_CHECKS_SVH
`define CUBE_CHECKS_SVH

typedef struct packed {
  cube_state_t state;
  cube_state_t care;    // Bits of state that are compared
  logic        solved;
  logic [15:0] turns;
} expect_t;

expect_t     exp_q [$];
logic [31:0] seed = 32'hd933_e875;
logic        saw_cmd_stall = 1'b0;

function automatic logic [31:0] lcg_step(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic move_t random_move();
  seed = lcg_step(seed);
  return move_t'(4'(seed[31:24] % 8'd12) + 4'd1);  // Codes 1 to 12
endfunction

function automatic move_t inverse_move(input move_t m);
  return m[0] ? move_t'(m + 4'd1) : move_t'(m - 4'd1);
endfunction

function automatic cube_state_t random_state();
  cube_state_t s;
  for (int i = 0; i < 12; i++) begin
    seed = lcg_step(seed);
    s.corner_perm[i]  = seed[30:28];
    s.corner_twist[i] = 2'(seed[27:20] % 8'd3);
    s.edge_perm[i]    = seed[19:16];
    s.edge_flip[i]    = seed[31];
  end
  s.edge_flip[0] = 1'b1;  // Keeps it unsolved
  return s;
endfunction

// Called and returns 1 ns after a rising edge
task automatic send_cmd(input cube_cmd_t c);
  logic accepted;
  cmd       = c;
  cmd_valid = 1'b1;
  accepted  = 1'b0;
  while (!accepted) begin
    @(negedge clk);
    accepted = cmd_ready;
    if (!cmd_ready) begin
      saw_cmd_stall = 1'b1;
    end
    @(posedge clk);
    #1;
  end
  cmd_valid = 1'b0;
endtask

task automatic load_state(input cube_state_t s);
  cube_cmd_t c;
  c       = '0;
  c.kind  = cmd_load;
  c.state = s;
  send_cmd(c);
endtask

task automatic do_turn(input move_t m);
  cube_cmd_t c;
  c      = '0;
  c.kind = cmd_turn;
  c.move = m;
  send_cmd(c);
endtask

task automatic request_report(input cube_state_t s, input cube_state_t care,
                              input logic solved, input logic [15:0] turns);
  cube_cmd_t c;
  expect_t   e;
  e = '{state: s, care: care, solved: solved, turns: turns};
  exp_q.push_back(e);
  c      = '0;
  c.kind = cmd_report;
  send_cmd(c);
endtask

task automatic drain_reports();
  while (exp_q.size() != 0) begin
    @(posedge clk);
    #1;
  end
endtask

task automatic check_report(input cube_report_t got);
  expect_t e;
  assert (exp_q.size() != 0) else abort_run("A report arrived that nobody requested");
  e = exp_q.pop_front();
  assert (((got.state ^ e.state) & e.care) == '0) else
    abort_run($sformatf("FAIL at %0t ns: rpt.state expected %h got %h",
                        $time, e.state, got.state));
  assert (got.solved == e.solved) else
    abort_run($sformatf("FAIL at %0t ns: rpt.solved expected %0b got %0b",
                        $time, e.solved, got.solved));
  assert (got.turns == e.turns) else
    abort_run($sformatf("FAIL at %0t ns: rpt.turns expected %0d got %0d",
                        $time, e.turns, got.turns));
endtask

`endif

//--- verification/cube_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cube_engine_tb;

  import cube_pkg::*;

  localparam int SEQ_LEN   = 10;
  localparam int RAND_SEQS = 4;
  localparam int BURSTS    = 3;
  localparam int BURST_LEN = 8;
  localparam int TOTAL_CMDS = 136 + RAND_SEQS * (2 * SEQ_LEN + 2) + BURSTS * BURST_LEN * 2;
  localparam int WATCHDOG_CYCLES = TOTAL_CMDS * 40 + 1000;

  logic         clk;
  logic         rst_n;
  logic         cmd_valid;
  logic         cmd_ready;
  cube_cmd_t    cmd;
  logic         rpt_valid;
  logic         rpt_ready;
  cube_report_t rpt;
  logic         stall_on;
  logic [31:0]  stall_seed;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  `include "cube_checks.svh"

  cube_engine #(
    .CMD_DEPTH (4),
    .RPT_DEPTH (2)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .rpt_valid (rpt_valid),
    .rpt_ready (rpt_ready),
    .rpt       (rpt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * 20);
    abort_run("Timeout: the tests did not finish within the cycle budget");
  end

  // Report sink is ready about a quarter of the time while stalling
  initial begin
    rpt_ready  = 1'b0;
    stall_seed = 32'hd933_e875;
    forever begin
      @(posedge clk);
      #1;
      if (stall_on) begin
        stall_seed = lcg_step(stall_seed);
        rpt_ready  = (stall_seed[31:30] == 2'b11);
      end else begin
        rpt_ready = 1'b1;
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      if (rst_n && rpt_valid && rpt_ready) begin
        check_report(rpt);  // Transfer at the next edge
      end
    end
  end

  initial begin
    cube_state_t s;
    cube_state_t exp_s;
    cube_state_t care;
    move_t       seq [SEQ_LEN];
    cmd_valid = 1'b0;
    cmd       = '0;
    rst_n     = 1'b0;
    stall_on  = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    assert (!rpt_valid && cmd_ready) else abort_run("Stream handshakes wrong after reset");

    load_state(solved_state);
    request_report(solved_state, '1, 1'b1, 16'd0);
    s = random_state();
    load_state(s);
    request_report(s, '1, 1'b0, 16'd0);
    drain_reports();

    for (int m = 1; m <= 12; m++) begin
      s = random_state();
      load_state(s);
      do_turn(move_t'(4'(m)));
      do_turn(inverse_move(move_t'(4'(m))));
      request_report(s, '1, 1'b0, 16'd2);
      load_state(s);
      repeat (4) do_turn(move_t'(4'(m)));
      request_report(s, '1, 1'b0, 16'd4);
    end
    drain_reports();

    exp_s           = '0;
    care            = '0;
    care.edge_flip  = '1;
    exp_s.edge_flip = 12'b0100_1100_0100;  // Slots 2, 6, 7 and 10
    load_state(solved_state);
    do_turn(mv_f);
    request_report(exp_s, care, 1'b0, 16'd1);
    exp_s                = '0;
    exp_s.corner_perm[0] = 3'd3;
    care                 = '0;
    care.corner_twist    = '1;
    care.edge_flip       = '1;
    care.corner_perm[0]  = 3'b111;
    load_state(solved_state);
    do_turn(mv_u);
    request_report(exp_s, care, 1'b0, 16'd1);
    drain_reports();

    s = random_state();
    load_state(s);
    do_turn(move_t'(4'd0));
    do_turn(move_t'(4'd13));
    do_turn(move_t'(4'd14));
    do_turn(move_t'(4'd15));
    request_report(s, '1, 1'b0, 16'd0);
    drain_reports();

    for (int n = 0; n < RAND_SEQS; n++) begin
      load_state(solved_state);
      for (int i = 0; i < SEQ_LEN; i++) begin
        seq[i] = random_move();
        do_turn(seq[i]);
      end
      for (int i = SEQ_LEN - 1; i >= 0; i--) begin
        do_turn(inverse_move(seq[i]));  // Undo in reverse
      end
      request_report(solved_state, '1, 1'b1, 16'(2 * SEQ_LEN));
    end
    drain_reports();

    saw_cmd_stall = 1'b0;
    stall_on      = 1'b1;
    for (int b = 0; b < BURSTS; b++) begin
      for (int i = 0; i < BURST_LEN; i++) begin
        s = random_state();
        load_state(s);
        request_report(s, '1, 1'b0, 16'd0);
      end
    end
    drain_reports();
    stall_on = 1'b0;
    assert (saw_cmd_stall) else abort_run("cmd_ready never dropped while reports were stalled");

    repeat (10) @(posedge clk);
    #1;
    assert (!rpt_valid && cmd_ready) else abort_run("DUT streams not idle at the end of the run");
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
